//--- design/axis_in_pkg.sv
package axis_in_pkg;

   // Processor bus word
   localparam int WB_DATA_W = 32;

   // Word addresses on wb_adr_i
   localparam logic [2:0] REG_CTRL      = 3'd0;
   localparam logic [2:0] REG_THRESHOLD = 3'd1;
   localparam logic [2:0] REG_DATA      = 3'd2;
   localparam logic [2:0] REG_STATUS    = 3'd3;
   localparam logic [2:0] REG_LEVEL     = 3'd4;

   // CTRL bits
   localparam int CTRL_SOFT_RESET = 0;
   localparam int CTRL_ENABLE     = 1;

   // STATUS bits
   localparam int STATUS_EMPTY    = 0;
   localparam int STATUS_LAST     = 1;
   // Strobe mask of the last popped word, one bit per lane
   localparam int STATUS_STRB_LSB = 8;

endpackage

//--- design/axis_in_sync.sv
`timescale 1ns/1ps

module axis_in_sync #(
   parameter int WIDTH = 1
) (
   input  logic             clk_i,
   input  logic [WIDTH-1:0] d_i,
   output logic [WIDTH-1:0] q_o
);

   logic [WIDTH-1:0] meta_q;

   always_ff @(posedge clk_i) begin
      meta_q <= d_i;
      q_o    <= meta_q;
   end

endmodule

//--- design/axis_in_ram_2p.sv
`timescale 1ns/1ps

module axis_in_ram_2p #(
   parameter int DATA_W = 10,
   parameter int ADDR_W = 3
) (
   input  logic              w_clk_i,
   input  logic              w_en_i,
   input  logic [ADDR_W-1:0] w_addr_i,
   input  logic [DATA_W-1:0] w_data_i,
   input  logic              r_clk_i,
   input  logic              r_en_i,
   input  logic [ADDR_W-1:0] r_addr_i,
   output logic [DATA_W-1:0] r_data_o
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge w_clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // Output holds until the next read
   always_ff @(posedge r_clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

//--- design/axis_in_fifo_async.sv
`timescale 1ns/1ps

module axis_in_fifo_async import axis_in_pkg::*; #(
   parameter int TDATA_W         = 8,
   parameter int FIFO_DEPTH_LOG2 = 5
) (
   input  logic                         w_clk_i,
   input  logic                         w_rst_i,
   input  logic                         w_en_i,
   input  logic [TDATA_W+1:0]           w_data_i,
   output logic                         w_full_o,
   input  logic                         r_clk_i,
   input  logic                         r_rst_i,
   input  logic                         r_en_i,
   output logic [WB_DATA_W-1:0]         r_data_o,
   output logic [WB_DATA_W/TDATA_W-1:0] r_strb_o,
   output logic [WB_DATA_W/TDATA_W-1:0] r_last_o,
   output logic                         r_empty_o,
   output logic [FIFO_DEPTH_LOG2:0]     r_level_o
);

   localparam int N          = WB_DATA_W / TDATA_W;
   localparam int LANE_W     = $clog2(N);
   localparam int RAM_ADDR_W = FIFO_DEPTH_LOG2 - LANE_W;
   localparam int PTR_W      = RAM_ADDR_W + 1;
   localparam int LVL_W      = FIFO_DEPTH_LOG2 + 1;

   logic [FIFO_DEPTH_LOG2:0] w_ptr;
   logic [PTR_W-1:0]         w_word;
   logic [PTR_W-1:0]         w_gray;
   logic [PTR_W-1:0]         w_gray_sync;
   logic [PTR_W-1:0]         w_word_sync;
   logic [PTR_W-1:0]         r_word;
   logic [PTR_W-1:0]         r_gray;
   logic [PTR_W-1:0]         r_gray_sync;
   logic [PTR_W-1:0]         r_word_sync;
   logic [PTR_W-1:0]         r_fill;
   logic                     r_flush;
   logic [TDATA_W+1:0]       bank_q [N];

   function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] g);
      logic [PTR_W-1:0] b;
      int               i;
      b[PTR_W-1] = g[PTR_W-1];
      for (i = PTR_W - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // Upper bits of the lane pointer count whole words
   assign w_word = w_ptr[FIFO_DEPTH_LOG2:LANE_W];

   always_ff @(posedge w_clk_i) begin
      if (w_rst_i) begin
         w_ptr  <= '0;
         w_gray <= '0;
      end else begin
         if (w_en_i) begin
            w_ptr <= w_ptr + 1'b1;
         end
         w_gray <= w_word ^ (w_word >> 1);
      end
   end

   axis_in_sync #(.WIDTH(PTR_W)) i_sync_r2w (
      .clk_i(w_clk_i),
      .d_i  (r_gray),
      .q_o  (r_gray_sync)
   );

   assign r_word_sync = gray2bin(r_gray_sync);
   // Slot of the word being filled still holds an unread word
   assign w_full_o = (w_word ^ r_word_sync) == {1'b1, {RAM_ADDR_W{1'b0}}};

   for (genvar p = 0; p < N; p++) begin : gen_bank
      axis_in_ram_2p #(
         .DATA_W(TDATA_W + 2),
         .ADDR_W(RAM_ADDR_W)
      ) i_ram (
         .w_clk_i (w_clk_i),
         .w_en_i  (w_en_i && ((w_ptr % N) == p)),
         .w_addr_i(w_word[RAM_ADDR_W-1:0]),
         .w_data_i(w_data_i),
         .r_clk_i (r_clk_i),
         .r_en_i  (r_en_i),
         .r_addr_i(r_word[RAM_ADDR_W-1:0]),
         .r_data_o(bank_q[p])
      );

      assign r_data_o[p*TDATA_W +: TDATA_W] = bank_q[p][TDATA_W-1:0];
      assign r_strb_o[p]                    = bank_q[p][TDATA_W];
      assign r_last_o[p]                    = bank_q[p][TDATA_W+1];
   end

   axis_in_sync #(.WIDTH(PTR_W)) i_sync_w2r (
      .clk_i(r_clk_i),
      .d_i  (w_gray),
      .q_o  (w_gray_sync)
   );

   assign w_word_sync = gray2bin(w_gray_sync);
   assign r_fill      = w_word_sync - r_word;

   always_ff @(posedge r_clk_i) begin
      if (r_rst_i) begin
         r_word  <= '0;
         r_gray  <= '0;
         r_flush <= 1'b1;
      end else begin
         if (r_en_i) begin
            r_word <= r_word + 1'b1;
         end
         r_gray <= r_word ^ (r_word >> 1);
         // Stale write pointer until the write side has seen its reset
         if (w_gray_sync == '0) begin
            r_flush <= 1'b0;
         end
      end
   end

   assign r_empty_o = r_flush || (r_fill == '0);
   assign r_level_o = r_flush ? '0 : LVL_W'(r_fill);

   assert property (@(posedge r_clk_i) disable iff (r_rst_i) r_en_i |-> !r_empty_o);

endmodule

//--- design/axis_in_packer.sv
`timescale 1ns/1ps

module axis_in_packer import axis_in_pkg::*; #(
   parameter int TDATA_W = 8
) (
   input  logic               axis_clk_i,
   input  logic               axis_rst_i,
   input  logic               enable_i,
   input  logic               axis_tvalid_i,
   input  logic               axis_tlast_i,
   input  logic [TDATA_W-1:0] axis_tdata_i,
   input  logic               fifo_full_i,
   output logic               axis_tready_o,
   output logic               lane_wen_o,
   output logic [TDATA_W-1:0] lane_data_o,
   output logic               lane_strb_o,
   output logic               lane_last_o
);

   localparam int   N         = WB_DATA_W / TDATA_W;
   localparam int   CNT_W     = (N > 1) ? $clog2(N) : 1;
   localparam logic ST_ACCEPT = 1'b0;
   localparam logic ST_PAD    = 1'b1;

   logic             state_q;
   logic [CNT_W-1:0] lane_q;
   logic             advance;
   logic             word_end;

   assign advance  = enable_i & ~fifo_full_i;
   assign word_end = (lane_q == CNT_W'(N - 1));

   assign axis_tready_o = advance & (state_q == ST_ACCEPT);
   assign lane_wen_o    = advance & ((state_q == ST_PAD) | axis_tvalid_i);
   // Padding lanes are all zero
   assign lane_data_o   = (state_q == ST_PAD) ? '0 : axis_tdata_i;
   assign lane_strb_o   = (state_q == ST_ACCEPT);
   assign lane_last_o   = (state_q == ST_ACCEPT) & axis_tlast_i;

   always_ff @(posedge axis_clk_i) begin
      if (axis_rst_i) begin
         state_q <= ST_ACCEPT;
         lane_q  <= '0;
      end else if (lane_wen_o) begin
         lane_q <= word_end ? '0 : lane_q + 1'b1;
         if (state_q == ST_PAD && word_end) begin
            state_q <= ST_ACCEPT;
         end else if (state_q == ST_ACCEPT && axis_tlast_i && !word_end) begin
            // Packet ended partway through a word
            state_q <= ST_PAD;
         end
      end
   end

   assert property (@(posedge axis_clk_i) disable iff (axis_rst_i)
      lane_wen_o |-> !fifo_full_i);

endmodule

//--- design/axis_in_regs.sv
`timescale 1ns/1ps

module axis_in_regs import axis_in_pkg::*; #(
   parameter int TDATA_W         = 8,
   parameter int FIFO_DEPTH_LOG2 = 5
) (
   input  logic                         clk_i,
   input  logic                         rst_i,
   input  logic                         wb_cyc_i,
   input  logic                         wb_stb_i,
   input  logic                         wb_we_i,
   input  logic [2:0]                   wb_adr_i,
   input  logic [WB_DATA_W-1:0]         wb_dat_i,
   output logic [WB_DATA_W-1:0]         wb_dat_o,
   output logic                         wb_ack_o,
   input  logic                         fifo_empty_i,
   input  logic [FIFO_DEPTH_LOG2:0]     fifo_level_i,
   input  logic [WB_DATA_W-1:0]         fifo_rdata_i,
   input  logic [WB_DATA_W/TDATA_W-1:0] fifo_rstrb_i,
   input  logic [WB_DATA_W/TDATA_W-1:0] fifo_rlast_i,
   output logic                         fifo_ren_o,
   output logic                         soft_reset_o,
   output logic                         enable_o,
   output logic                         threshold_o
);

   localparam int N = WB_DATA_W / TDATA_W;

   logic [1:0]           ctrl_q;
   logic [WB_DATA_W-1:0] threshold_q;
   logic                 acked_q;
   logic                 pop_q;
   logic                 word_valid_q;
   logic                 req;
   logic                 access;

   assign req = wb_cyc_i & wb_stb_i;
   // First cycle of an access not yet acked
   assign access = req & ~wb_ack_o & ~acked_q;

   assign fifo_ren_o = access & ~wb_we_i & (wb_adr_i == REG_DATA) & ~fifo_empty_i;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wb_ack_o    <= 1'b0;
         acked_q     <= 1'b0;
         ctrl_q      <= '0;
         threshold_q <= '0;
      end else begin
         wb_ack_o <= access;
         // Held until the strobe drops
         acked_q  <= req & (acked_q | wb_ack_o);
         if (access && wb_we_i) begin
            case (wb_adr_i)
               REG_CTRL: begin
                  ctrl_q[CTRL_SOFT_RESET] <= wb_dat_i[CTRL_SOFT_RESET];
                  ctrl_q[CTRL_ENABLE]     <= wb_dat_i[CTRL_ENABLE];
               end
               REG_THRESHOLD: threshold_q <= wb_dat_i;
               default: ;
            endcase
         end
      end
   end

   // Popped word is held in the FIFO read register
   always_ff @(posedge clk_i) begin
      if (rst_i || ctrl_q[CTRL_SOFT_RESET]) begin
         pop_q        <= 1'b0;
         word_valid_q <= 1'b0;
      end else begin
         pop_q <= fifo_ren_o;
         if (fifo_ren_o) begin
            word_valid_q <= 1'b1;
         end
      end
   end

   assign soft_reset_o = ctrl_q[CTRL_SOFT_RESET];
   assign enable_o     = ctrl_q[CTRL_ENABLE] & ~ctrl_q[CTRL_SOFT_RESET];
   assign threshold_o  = (threshold_q != '0) &&
                         (WB_DATA_W'(fifo_level_i) >= threshold_q);

   always_comb begin
      wb_dat_o = '0;
      case (wb_adr_i)
         REG_CTRL: begin
            wb_dat_o[CTRL_SOFT_RESET] = ctrl_q[CTRL_SOFT_RESET];
            wb_dat_o[CTRL_ENABLE]     = ctrl_q[CTRL_ENABLE];
         end
         REG_THRESHOLD: wb_dat_o = threshold_q;
         REG_DATA: begin
            if (pop_q) begin
               wb_dat_o = fifo_rdata_i;
            end
         end
         REG_STATUS: begin
            wb_dat_o[STATUS_EMPTY] = fifo_empty_i;
            if (word_valid_q) begin
               wb_dat_o[STATUS_LAST]            = |fifo_rlast_i;
               wb_dat_o[STATUS_STRB_LSB +: N]   = fifo_rstrb_i;
            end
         end
         REG_LEVEL: wb_dat_o[FIFO_DEPTH_LOG2:0] = fifo_level_i;
         default: ;
      endcase
   end

   assert property (@(posedge clk_i) disable iff (rst_i) wb_ack_o |=> !wb_ack_o);
   assert property (@(posedge clk_i) disable iff (rst_i) fifo_ren_o |-> !fifo_empty_i);

endmodule

//--- design/axis_in.sv
`timescale 1ns/1ps

module axis_in import axis_in_pkg::*; #(
   parameter int TDATA_W         = 8,
   parameter int FIFO_DEPTH_LOG2 = 5
) (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 axis_clk_i,
   input  logic                 wb_cyc_i,
   input  logic                 wb_stb_i,
   input  logic                 wb_we_i,
   input  logic [2:0]           wb_adr_i,
   input  logic [WB_DATA_W-1:0] wb_dat_i,
   output logic [WB_DATA_W-1:0] wb_dat_o,
   output logic                 wb_ack_o,
   input  logic [TDATA_W-1:0]   axis_tdata_i,
   input  logic                 axis_tvalid_i,
   input  logic                 axis_tlast_i,
   output logic                 axis_tready_o,
   output logic                 threshold_o
);

   localparam int N = WB_DATA_W / TDATA_W;

   logic                     fifo_empty;
   logic [FIFO_DEPTH_LOG2:0] fifo_level;
   logic [WB_DATA_W-1:0]     fifo_rdata;
   logic [N-1:0]             fifo_rstrb;
   logic [N-1:0]             fifo_rlast;
   logic                     fifo_ren;
   logic                     fifo_full;
   logic                     soft_reset;
   logic                     enable;
   logic                     r_rst;
   logic                     axis_rst;
   logic                     axis_enable;
   logic                     lane_wen;
   logic [TDATA_W-1:0]       lane_data;
   logic                     lane_strb;
   logic                     lane_last;

   assign r_rst = rst_i | soft_reset;

   axis_in_regs #(
      .TDATA_W        (TDATA_W),
      .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
   ) i_regs (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .wb_cyc_i    (wb_cyc_i),
      .wb_stb_i    (wb_stb_i),
      .wb_we_i     (wb_we_i),
      .wb_adr_i    (wb_adr_i),
      .wb_dat_i    (wb_dat_i),
      .wb_dat_o    (wb_dat_o),
      .wb_ack_o    (wb_ack_o),
      .fifo_empty_i(fifo_empty),
      .fifo_level_i(fifo_level),
      .fifo_rdata_i(fifo_rdata),
      .fifo_rstrb_i(fifo_rstrb),
      .fifo_rlast_i(fifo_rlast),
      .fifo_ren_o  (fifo_ren),
      .soft_reset_o(soft_reset),
      .enable_o    (enable),
      .threshold_o (threshold_o)
   );

   // Reset and enable into the stream domain
   axis_in_sync #(.WIDTH(2)) i_sync_ctrl (
      .clk_i(axis_clk_i),
      .d_i  ({r_rst, enable}),
      .q_o  ({axis_rst, axis_enable})
   );

   axis_in_packer #(.TDATA_W(TDATA_W)) i_packer (
      .axis_clk_i   (axis_clk_i),
      .axis_rst_i   (axis_rst),
      .enable_i     (axis_enable),
      .axis_tvalid_i(axis_tvalid_i),
      .axis_tlast_i (axis_tlast_i),
      .axis_tdata_i (axis_tdata_i),
      .fifo_full_i  (fifo_full),
      .axis_tready_o(axis_tready_o),
      .lane_wen_o   (lane_wen),
      .lane_data_o  (lane_data),
      .lane_strb_o  (lane_strb),
      .lane_last_o  (lane_last)
   );

   axis_in_fifo_async #(
      .TDATA_W        (TDATA_W),
      .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
   ) i_fifo (
      .w_clk_i  (axis_clk_i),
      .w_rst_i  (axis_rst),
      .w_en_i   (lane_wen),
      .w_data_i ({lane_last, lane_strb, lane_data}),
      .w_full_o (fifo_full),
      .r_clk_i  (clk_i),
      .r_rst_i  (r_rst),
      .r_en_i   (fifo_ren),
      .r_data_o (fifo_rdata),
      .r_strb_o (fifo_rstrb),
      .r_last_o (fifo_rlast),
      .r_empty_o(fifo_empty),
      .r_level_o(fifo_level)
   );

endmodule

//--- tb/tb_axis_in.sv
`timescale 1ns/1ps

module tb_axis_in import axis_in_pkg::*;;

   localparam int TDATA_W         = 8;
   localparam int FIFO_DEPTH_LOG2 = 5;
   localparam int N               = WB_DATA_W / TDATA_W;

   logic                 clk_i;
   logic                 rst_i;
   logic                 axis_clk_i;
   logic                 wb_cyc_i;
   logic                 wb_stb_i;
   logic                 wb_we_i;
   logic [2:0]           wb_adr_i;
   logic [WB_DATA_W-1:0] wb_dat_i;
   logic [WB_DATA_W-1:0] wb_dat_o;
   logic                 wb_ack_o;
   logic [TDATA_W-1:0]   axis_tdata_i;
   logic                 axis_tvalid_i;
   logic                 axis_tlast_i;
   logic                 axis_tready_o;
   logic                 threshold_o;

   logic [31:0]          lfsr = 32'h8ead3a12;
   logic [TDATA_W-1:0]   pkt_q[$];
   logic [31:0]          exp_word[$];
   logic [N-1:0]         exp_strb[$];
   logic                 exp_last[$];

   axis_in #(
      .TDATA_W        (TDATA_W),
      .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
   ) i_axis_in (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .axis_clk_i   (axis_clk_i),
      .wb_cyc_i     (wb_cyc_i),
      .wb_stb_i     (wb_stb_i),
      .wb_we_i      (wb_we_i),
      .wb_adr_i     (wb_adr_i),
      .wb_dat_i     (wb_dat_i),
      .wb_dat_o     (wb_dat_o),
      .wb_ack_o     (wb_ack_o),
      .axis_tdata_i (axis_tdata_i),
      .axis_tvalid_i(axis_tvalid_i),
      .axis_tlast_i (axis_tlast_i),
      .axis_tready_o(axis_tready_o),
      .threshold_o  (threshold_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   initial begin
      axis_clk_i = 1'b0;
      forever #3 axis_clk_i = ~axis_clk_i;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
      end
   endtask

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      int i;
      v = '0;
      for (i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   // Expected words of one packet padded out to whole words
   function automatic void pack_packet(input logic [TDATA_W-1:0] lanes[$]);
      int           w;
      int           k;
      int           idx;
      logic [31:0]  word;
      logic [N-1:0] strb;
      logic         last;
      for (w = 0; w < (lanes.size() + N - 1) / N; w++) begin
         word = '0;
         strb = '0;
         last = 1'b0;
         for (k = 0; k < N; k++) begin
            idx = w * N + k;
            if (idx < lanes.size()) begin
               word[k*TDATA_W +: TDATA_W] = lanes[idx];
               strb[k] = 1'b1;
               if (idx == lanes.size() - 1) begin
                  last = 1'b1;
               end
            end
         end
         exp_word.push_back(word);
         exp_strb.push_back(strb);
         exp_last.push_back(last);
      end
   endfunction

   task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
      int n;
      @(posedge clk_i);
      #1;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = wdata;
      n = 0;
      do begin
         @(posedge clk_i);
         #1;
         n++;
         if (n > 20) begin
            abort_run("bus access got no ack");
         end
      end while (!wb_ack_o);
      rdata    = wb_dat_o;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      // Strobe must be seen low before the next access
      @(posedge clk_i);
      #1;
   endtask

   task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
      logic [31:0] unused;
      wb_access(1'b1, adr, data, unused);
   endtask

   task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
      wb_access(1'b0, adr, '0, data);
   endtask

   task automatic make_packet(input int len);
      int          i;
      logic [31:0] v;
      pkt_q.delete();
      for (i = 0; i < len; i++) begin
         take_bits(TDATA_W, v);
         pkt_q.push_back(v[TDATA_W-1:0]);
      end
      pack_packet(pkt_q);
   endtask

   task automatic drive_packet();
      int          i;
      int          n;
      logic [31:0] g;
      @(posedge axis_clk_i);
      #1;
      for (i = 0; i < pkt_q.size(); i++) begin
         take_bits(2, g);
         if (g[1]) begin
            axis_tvalid_i = 1'b0;
            repeat (g[1:0]) begin
               @(posedge axis_clk_i);
               #1;
            end
         end
         axis_tvalid_i = 1'b1;
         axis_tdata_i  = pkt_q[i];
         axis_tlast_i  = (i == pkt_q.size() - 1);
         n = 0;
         while (!axis_tready_o) begin
            @(posedge axis_clk_i);
            #1;
            n++;
            if (n > 400) begin
               abort_run("stream lane was not accepted in time");
            end
         end
         @(posedge axis_clk_i);
         #1;
      end
      axis_tvalid_i = 1'b0;
      axis_tlast_i  = 1'b0;
   endtask

   task automatic send_packet(input int len);
      make_packet(len);
      drive_packet();
   endtask

   // Pops words and compares them with the reference queues
   task automatic drain_words(input int count);
      int          i;
      int          n;
      logic [31:0] d;
      logic [31:0] s;
      for (i = 0; i < count; i++) begin
         n = 0;
         wb_read(REG_STATUS, s);
         while (s[STATUS_EMPTY]) begin
            n++;
            if (n > 300) begin
               abort_run("FIFO stayed empty while words were expected");
            end
            wb_read(REG_STATUS, s);
         end
         wb_read(REG_DATA, d);
         wb_read(REG_STATUS, s);
         check_value("data word", exp_word.pop_front(), d);
         check_value("strobe mask", exp_strb.pop_front(), s[STATUS_STRB_LSB +: N]);
         check_value("last flag", exp_last.pop_front(), s[STATUS_LAST]);
      end
   endtask

   task automatic wait_level(input int level);
      int          n;
      logic [31:0] d;
      n = 0;
      wb_read(REG_LEVEL, d);
      while (d != level) begin
         n++;
         if (n > 300) begin
            abort_run("LEVEL did not reach the expected value");
         end
         wb_read(REG_LEVEL, d);
      end
   endtask

   initial begin
      logic [31:0] d;
      int          n;
      wb_cyc_i      = 1'b0;
      wb_stb_i      = 1'b0;
      wb_we_i       = 1'b0;
      wb_adr_i      = '0;
      wb_dat_i      = '0;
      axis_tdata_i  = '0;
      axis_tvalid_i = 1'b0;
      axis_tlast_i  = 1'b0;
      rst_i         = 1'b1;
      repeat (16) @(posedge clk_i);
      #1;
      rst_i = 1'b0;

      wb_read(REG_CTRL, d);
      check_value("reset ctrl", 32'h0, d);
      wb_read(REG_THRESHOLD, d);
      check_value("reset threshold", 32'h0, d);
      wb_read(REG_LEVEL, d);
      check_value("reset level", 32'h0, d);
      wb_read(REG_STATUS, d);
      check_value("reset status", 32'h1, d);
      check_value("reset tready", 32'h0, axis_tready_o);
      check_value("reset threshold_o", 32'h0, threshold_o);

      wb_write(REG_CTRL, 32'h1 << CTRL_ENABLE);
      wb_write(REG_THRESHOLD, 32'd6);
      wb_read(REG_CTRL, d);
      check_value("ctrl readback", 32'h1 << CTRL_ENABLE, d);
      wb_read(REG_THRESHOLD, d);
      check_value("threshold readback", 32'd6, d);
      n = 0;
      @(posedge axis_clk_i);
      #1;
      while (!axis_tready_o) begin
         @(posedge axis_clk_i);
         #1;
         n++;
         if (n > 50) begin
            abort_run("tready did not rise after enable");
         end
      end

      // Whole packets
      send_packet(4);
      send_packet(8);
      send_packet(12);
      drain_words(exp_word.size());

      // Packets ending inside a word
      send_packet(5);
      send_packet(6);
      send_packet(7);
      drain_words(exp_word.size());
      send_packet(1);
      send_packet(2);
      send_packet(3);
      drain_words(exp_word.size());

      // Fill the FIFO and keep offering lanes while it is full
      check_value("threshold_o when empty", 32'h0, threshold_o);
      send_packet(32);
      make_packet(8);
      fork
         drive_packet();
         begin
            repeat (20) begin
               @(posedge axis_clk_i);
               #1;
               check_value("tready when full", 32'h0, axis_tready_o);
            end
            wait_level(8);
            check_value("threshold_o at level 8", 32'(8 >= 6), threshold_o);
            drain_words(exp_word.size());
         end
      join
      wb_read(REG_LEVEL, d);
      check_value("level after drain", 32'h0, d);

      // Soft reset with words queued
      send_packet(8);
      wait_level(2);
      wb_write(REG_CTRL, (32'h1 << CTRL_SOFT_RESET) | (32'h1 << CTRL_ENABLE));
      repeat (10) @(posedge clk_i);
      #1;
      wb_write(REG_CTRL, 32'h1 << CTRL_ENABLE);
      exp_word.delete();
      exp_strb.delete();
      exp_last.delete();
      wb_read(REG_STATUS, d);
      check_value("status after soft reset", 32'h1, d);
      wb_read(REG_LEVEL, d);
      check_value("level after soft reset", 32'h0, d);
      send_packet(6);
      drain_words(exp_word.size());

      $display("PASS: all tests");
      $finish;
   end

endmodule

//--- sim.f
design/axis_in_pkg.sv
design/axis_in_sync.sv
design/axis_in_ram_2p.sv
design/axis_in_fifo_async.sv
design/axis_in_packer.sv
design/axis_in_regs.sv
design/axis_in.sv
tb/tb_axis_in.sv
